/* verilog/dma_pkg.sv */
package dma_pkg;

    localparam int NUM_CHANNELS = 4;
    localparam int CH_W = $clog2(NUM_CHANNELS);   // channel index width

    typedef logic [27:0]             addr_t;
    typedef logic [31:0]             word_t;
    typedef logic [16:0]             count_t;     // one more bit for 65536 units
    typedef logic [7:0]              reg_adr_t;
    typedef logic [NUM_CHANNELS-1:0] chan_vec_t;

    // register map with one block of three words per channel
    localparam reg_adr_t REG_BASE = 8'hB0;
    localparam int REG_STRIDE = 12;
    localparam int SAD_OFS = 0;
    localparam int DAD_OFS = 4;
    localparam int CNT_OFS = 8;

    // CNT word layout
    localparam int CNT_H_LSB    = 16;   // unit count sits below this
    localparam int DST_CTRL_LSB = 21;
    localparam int SRC_CTRL_LSB = 23;
    localparam int REPEAT_BIT   = 25;
    localparam int DWORD_BIT    = 26;
    localparam int TIMING_LSB   = 28;
    localparam int IRQ_BIT      = 30;
    localparam int ENABLE_BIT   = 31;

    typedef enum logic [1:0] {
        START_NOW,
        START_VBLANK,
        START_HBLANK,
        START_SPECIAL       // no trigger source in this design
    } start_timing_t;

    typedef enum logic [1:0] {
        ADR_INC,
        ADR_DEC,
        ADR_FIXED,
        ADR_INC_RELOAD
    } addr_ctrl_t;

    typedef enum logic [1:0] {CH_IDLE, CH_WAIT, CH_RUN} chan_state_t;

    typedef enum logic [1:0] {ENG_IDLE, ENG_READ, ENG_WRITE, ENG_DONE} engine_state_t;

endpackage

/* verilog/dma_regs.sv */
module dma_regs (
    input  logic                   clk100,
    input  logic                   reset,
    input  logic                   reg_ena,
    input  logic                   reg_rnw,
    input  dma_pkg::reg_adr_t      reg_adr,
    input  dma_pkg::word_t         reg_wdata,
    input  dma_pkg::chan_vec_t     active,
    output dma_pkg::word_t         reg_rdata,
    output logic                   reg_rvalid,
    output dma_pkg::addr_t         sad [dma_pkg::NUM_CHANNELS],
    output dma_pkg::addr_t         dad [dma_pkg::NUM_CHANNELS],
    output logic [15:0]            cnt_l [dma_pkg::NUM_CHANNELS],
    output dma_pkg::addr_ctrl_t    dst_ctrl [dma_pkg::NUM_CHANNELS],
    output dma_pkg::addr_ctrl_t    src_ctrl [dma_pkg::NUM_CHANNELS],
    output dma_pkg::chan_vec_t     repeat_en,
    output dma_pkg::chan_vec_t     dword,
    output dma_pkg::chan_vec_t     irq_en,
    output dma_pkg::start_timing_t timing [dma_pkg::NUM_CHANNELS],
    output dma_pkg::chan_vec_t     enable_wr,
    output dma_pkg::chan_vec_t     enable_val
);
    import dma_pkg::*;

    logic [CH_W-1:0] hit_ch;
    logic            hit_sad;
    logic            hit_dad;
    logic            hit_cnt;
    logic            wr;
    word_t           cnt_rd;

    assign wr = reg_ena & ~reg_rnw;

    // address -> channel + field
    always_comb begin
        hit_ch  = '0;
        hit_sad = 1'b0;
        hit_dad = 1'b0;
        hit_cnt = 1'b0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (reg_adr == reg_adr_t'(REG_BASE + i * REG_STRIDE + SAD_OFS)) begin
                hit_ch  = CH_W'(i);
                hit_sad = 1'b1;
            end
            if (reg_adr == reg_adr_t'(REG_BASE + i * REG_STRIDE + DAD_OFS)) begin
                hit_ch  = CH_W'(i);
                hit_dad = 1'b1;
            end
            if (reg_adr == reg_adr_t'(REG_BASE + i * REG_STRIDE + CNT_OFS)) begin
                hit_ch  = CH_W'(i);
                hit_cnt = 1'b1;
            end
        end
    end

    // CNT readback with the count field read as zero
    always_comb begin
        cnt_rd = '0;
        cnt_rd[DST_CTRL_LSB +: 2] = dst_ctrl[hit_ch];
        cnt_rd[SRC_CTRL_LSB +: 2] = src_ctrl[hit_ch];
        cnt_rd[REPEAT_BIT]        = repeat_en[hit_ch];
        cnt_rd[DWORD_BIT]         = dword[hit_ch];
        cnt_rd[TIMING_LSB +: 2]   = timing[hit_ch];
        cnt_rd[IRQ_BIT]           = irq_en[hit_ch];
        cnt_rd[ENABLE_BIT]        = active[hit_ch];   // live enable from the channel
    end

    always_ff @(posedge clk100) begin
        if (reset) begin
            enable_wr  <= '0;
            enable_val <= '0;
            repeat_en  <= '0;
            dword      <= '0;
            irq_en     <= '0;
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                dst_ctrl[i] <= ADR_INC;
                src_ctrl[i] <= ADR_INC;
                timing[i]   <= START_NOW;
            end
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                enable_wr[i] <= wr & hit_cnt & (hit_ch == CH_W'(i));
                if (wr && hit_cnt && hit_ch == CH_W'(i)) begin
                    dst_ctrl[i]   <= addr_ctrl_t'(reg_wdata[DST_CTRL_LSB +: 2]);
                    src_ctrl[i]   <= addr_ctrl_t'(reg_wdata[SRC_CTRL_LSB +: 2]);
                    repeat_en[i]  <= reg_wdata[REPEAT_BIT];
                    dword[i]      <= reg_wdata[DWORD_BIT];
                    timing[i]     <= start_timing_t'(reg_wdata[TIMING_LSB +: 2]);
                    irq_en[i]     <= reg_wdata[IRQ_BIT];
                    enable_val[i] <= reg_wdata[ENABLE_BIT];
                end
            end
        end
    end

    // bit 27 of an address is only reachable on some channels
    always_ff @(posedge clk100) begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (wr && hit_ch == CH_W'(i)) begin
                if (hit_sad)
                    sad[i] <= {reg_wdata[27] & (i != 0), reg_wdata[26:0]};
                if (hit_dad)
                    dad[i] <= {reg_wdata[27] & (i == NUM_CHANNELS - 1), reg_wdata[26:0]};
                if (hit_cnt)
                    cnt_l[i] <= reg_wdata[CNT_H_LSB-1:0];
            end
        end
    end

    always_ff @(posedge clk100) begin
        if (reset)
            reg_rvalid <= 1'b0;
        else
            reg_rvalid <= reg_ena & reg_rnw & (hit_sad | hit_dad | hit_cnt);
    end

    always_ff @(posedge clk100) begin
        reg_rdata <= hit_cnt ? cnt_rd : '0;   // SAD and DAD are write only
    end

endmodule

/* verilog/dma_channel.sv */
module dma_channel #(
    parameter int CHANNEL_INDEX = 0
) (
    input  logic                   clk100,
    input  logic                   reset,
    input  dma_pkg::addr_t         sad,
    input  dma_pkg::addr_t         dad,
    input  logic [15:0]            cnt_l,
    input  dma_pkg::addr_ctrl_t    dst_ctrl,
    input  dma_pkg::addr_ctrl_t    src_ctrl,
    input  logic                   repeat_en,
    input  logic                   word_size,
    input  logic                   irq_en,
    input  dma_pkg::start_timing_t timing,
    input  logic                   enable_wr,
    input  logic                   enable_val,
    input  logic                   vblank,
    input  logic                   hblank,
    input  logic                   unit_done,
    output logic                   active,
    output logic                   xfer_req,
    output dma_pkg::addr_t         src_adr,
    output dma_pkg::addr_t         dst_adr,
    output logic                   dword,
    output logic                   irq
);
    import dma_pkg::*;

    chan_state_t   state;
    addr_ctrl_t    dst_mode;
    addr_ctrl_t    src_mode;
    start_timing_t tmg;
    logic          rep;
    logic          irq_on;
    count_t        count;
    logic          start;
    logic          trig;
    logic          last;
    logic          rearm;

    // zero in the count field means the maximum
    function automatic count_t unit_count(input logic [15:0] c);
        if (CHANNEL_INDEX == NUM_CHANNELS - 1)
            return (c == 16'h0) ? count_t'(17'h10000) : count_t'(c);
        return (c[13:0] == 14'h0) ? count_t'(17'h04000) : count_t'(c[13:0]);
    endfunction

    function automatic addr_t next_adr(input addr_t a, input addr_ctrl_t mode, input logic dw);
        addr_t step;
        step = dw ? addr_t'(4) : addr_t'(2);
        case (mode)
            ADR_INC, ADR_INC_RELOAD: next_adr = a + step;
            ADR_DEC:                 next_adr = a - step;
            default:                 next_adr = a;
        endcase
    endfunction

    assign start    = enable_wr & enable_val & ~active;   // 0 -> 1 enable edge
    assign xfer_req = (state == CH_RUN);
    assign last     = xfer_req & unit_done & (count == count_t'(1));
    assign rearm    = rep & (tmg != START_NOW);

    always_comb begin
        case (tmg)
            START_NOW:    trig = 1'b1;
            START_VBLANK: trig = vblank;
            START_HBLANK: trig = hblank;
            default:      trig = 1'b0;
        endcase
    end

    always_ff @(posedge clk100) begin
        if (reset) begin
            state  <= CH_IDLE;
            active <= 1'b0;
            irq    <= 1'b0;
        end else begin
            irq <= 1'b0;
            case (state)
                CH_WAIT: if (trig) state <= CH_RUN;
                CH_RUN: begin
                    if (last) begin
                        irq <= irq_on;
                        if (rearm) begin
                            state <= CH_WAIT;   // next trigger starts a fresh block
                        end else begin
                            state  <= CH_IDLE;
                            active <= 1'b0;
                        end
                    end
                end
                default: ;
            endcase
            // register writes override the sequencing
            if (enable_wr) begin
                active <= enable_val;
                if (!enable_val)
                    state <= CH_IDLE;
                else if (!active)
                    state <= CH_WAIT;
            end
        end
    end

    always_ff @(posedge clk100) begin
        if (start) begin
            dst_mode <= dst_ctrl;
            src_mode <= src_ctrl;
            tmg      <= timing;
            rep      <= repeat_en;
            irq_on   <= irq_en;
            dword    <= word_size;
            src_adr  <= sad;
            dst_adr  <= dad;
            count    <= unit_count(cnt_l);
        end else if (xfer_req && unit_done) begin
            src_adr <= next_adr(src_adr, src_mode, dword);
            dst_adr <= next_adr(dst_adr, dst_mode, dword);
            count   <= count - count_t'(1);
            if (last && rearm) begin
                count <= unit_count(cnt_l);
                if (dst_mode == ADR_INC_RELOAD)
                    dst_adr <= dad;     // block restarts at programmed DAD
            end
        end
    end

endmodule

/* verilog/dma_bus_engine.sv */
module dma_bus_engine (
    input  logic               clk100,
    input  logic               reset,
    input  dma_pkg::chan_vec_t xfer_req,
    input  dma_pkg::addr_t     src_adr [dma_pkg::NUM_CHANNELS],
    input  dma_pkg::addr_t     dst_adr [dma_pkg::NUM_CHANNELS],
    input  dma_pkg::chan_vec_t dword,
    input  logic               mem_done,
    input  dma_pkg::word_t     mem_rdata,
    output dma_pkg::chan_vec_t unit_done,
    output logic               mem_ena,
    output logic               mem_rnw,
    output dma_pkg::addr_t     mem_adr,
    output logic               mem_dword,
    output dma_pkg::word_t     mem_wdata,
    output logic               dma_on
);
    import dma_pkg::*;

    engine_state_t   state;
    logic [CH_W-1:0] pick;
    chan_vec_t       grant;
    addr_t           wr_adr;      // aligned destination of the unit
    logic            src_half;    // source bit 1 picks the halfword
    logic [15:0]     rd_half;

    function automatic addr_t align(input addr_t a, input logic dw);
        return dw ? {a[27:2], 2'b00} : {a[27:1], 1'b0};
    endfunction

    // lowest index wins
    always_comb begin
        pick = '0;
        for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
            if (xfer_req[i])
                pick = CH_W'(i);
        end
    end

    assign rd_half = src_half ? mem_rdata[31:16] : mem_rdata[15:0];
    assign dma_on  = (|xfer_req) | (state != ENG_IDLE);

    always_ff @(posedge clk100) begin
        if (reset) begin
            state     <= ENG_IDLE;
            grant     <= '0;
            mem_ena   <= 1'b0;
            unit_done <= '0;
        end else begin
            mem_ena   <= 1'b0;
            unit_done <= '0;
            case (state)
                ENG_IDLE: begin
                    if (|xfer_req) begin
                        grant   <= chan_vec_t'(1) << pick;
                        mem_ena <= 1'b1;            // read strobe
                        state   <= ENG_READ;
                    end
                end
                ENG_READ: begin
                    if (mem_done) begin
                        mem_ena <= 1'b1;            // write strobe
                        state   <= ENG_WRITE;
                    end
                end
                ENG_WRITE: begin
                    if (mem_done) begin
                        unit_done <= grant;
                        state     <= ENG_DONE;
                    end
                end
                default: state <= ENG_IDLE;         // gap while the channel updates
            endcase
        end
    end

    // bus payload follows the state machine
    always_ff @(posedge clk100) begin
        case (state)
            ENG_IDLE: begin
                if (|xfer_req) begin
                    mem_rnw   <= 1'b1;
                    mem_dword <= dword[pick];
                    mem_adr   <= align(src_adr[pick], dword[pick]);
                    wr_adr    <= align(dst_adr[pick], dword[pick]);
                    src_half  <= src_adr[pick][1];
                end
            end
            ENG_READ: begin
                if (mem_done) begin
                    mem_rnw   <= 1'b0;
                    mem_adr   <= wr_adr;
                    mem_wdata <= mem_dword ? mem_rdata : {rd_half, rd_half};
                end
            end
            default: ;
        endcase
    end

endmodule

/* verilog/dma_top.sv */
module dma_top (
    input  logic               clk100,
    input  logic               reset,
    input  logic               reg_ena,
    input  logic               reg_rnw,
    input  dma_pkg::reg_adr_t  reg_adr,
    input  dma_pkg::word_t     reg_wdata,
    input  logic               vblank,
    input  logic               hblank,
    input  logic               mem_done,
    input  dma_pkg::word_t     mem_rdata,
    output dma_pkg::word_t     reg_rdata,
    output logic               reg_rvalid,
    output dma_pkg::chan_vec_t irq,
    output logic               dma_on,      // holds the CPU
    output logic               mem_ena,
    output logic               mem_rnw,
    output dma_pkg::addr_t     mem_adr,
    output logic               mem_dword,
    output dma_pkg::word_t     mem_wdata
);
    import dma_pkg::*;

    addr_t         sad [NUM_CHANNELS];
    addr_t         dad [NUM_CHANNELS];
    logic [15:0]   cnt_l [NUM_CHANNELS];
    addr_ctrl_t    dst_ctrl [NUM_CHANNELS];
    addr_ctrl_t    src_ctrl [NUM_CHANNELS];
    start_timing_t timing [NUM_CHANNELS];
    chan_vec_t     repeat_en;
    chan_vec_t     cfg_dword;
    chan_vec_t     irq_en;
    chan_vec_t     enable_wr;
    chan_vec_t     enable_val;
    chan_vec_t     active;
    chan_vec_t     xfer_req;
    chan_vec_t     xfer_dword;
    chan_vec_t     unit_done;
    addr_t         src_adr [NUM_CHANNELS];
    addr_t         dst_adr [NUM_CHANNELS];

    dma_regs u_regs (
        .clk100     (clk100),
        .reset      (reset),
        .reg_ena    (reg_ena),
        .reg_rnw    (reg_rnw),
        .reg_adr    (reg_adr),
        .reg_wdata  (reg_wdata),
        .active     (active),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .sad        (sad),
        .dad        (dad),
        .cnt_l      (cnt_l),
        .dst_ctrl   (dst_ctrl),
        .src_ctrl   (src_ctrl),
        .repeat_en  (repeat_en),
        .dword      (cfg_dword),
        .irq_en     (irq_en),
        .timing     (timing),
        .enable_wr  (enable_wr),
        .enable_val (enable_val)
    );

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        dma_channel #(
            .CHANNEL_INDEX (i)
        ) u_channel (
            .clk100     (clk100),
            .reset      (reset),
            .sad        (sad[i]),
            .dad        (dad[i]),
            .cnt_l      (cnt_l[i]),
            .dst_ctrl   (dst_ctrl[i]),
            .src_ctrl   (src_ctrl[i]),
            .repeat_en  (repeat_en[i]),
            .word_size  (cfg_dword[i]),
            .irq_en     (irq_en[i]),
            .timing     (timing[i]),
            .enable_wr  (enable_wr[i]),
            .enable_val (enable_val[i]),
            .vblank     (vblank),
            .hblank     (hblank),
            .unit_done  (unit_done[i]),
            .active     (active[i]),
            .xfer_req   (xfer_req[i]),
            .src_adr    (src_adr[i]),
            .dst_adr    (dst_adr[i]),
            .dword      (xfer_dword[i]),
            .irq        (irq[i])
        );
    end

    dma_bus_engine u_engine (
        .clk100    (clk100),
        .reset     (reset),
        .xfer_req  (xfer_req),
        .src_adr   (src_adr),
        .dst_adr   (dst_adr),
        .dword     (xfer_dword),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .unit_done (unit_done),
        .mem_ena   (mem_ena),
        .mem_rnw   (mem_rnw),
        .mem_adr   (mem_adr),
        .mem_dword (mem_dword),
        .mem_wdata (mem_wdata),
        .dma_on    (dma_on)
    );

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
    output logic clk100,
    output logic reset
);

    initial begin
        clk100 = 1'b0;
        forever #10 clk100 = ~clk100;   // period 20
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk100);
        #2;
        reset = 1'b0;
    end

endmodule

/* testbench/tb_memory.sv */
module tb_memory (
    input  logic           clk100,
    input  logic           reset,
    input  logic           mem_ena,
    input  logic           mem_rnw,
    input  dma_pkg::addr_t mem_adr,
    input  logic           mem_dword,
    input  dma_pkg::word_t mem_wdata,
    input  logic [1:0]     next_lat,    // extra wait cycles for the next access
    output logic           mem_done,
    output dma_pkg::word_t mem_rdata,
    output logic           wr_seen,
    output dma_pkg::addr_t wr_adr,
    output dma_pkg::word_t wr_data,
    output logic           wr_dword
);
    import dma_pkg::*;

    word_t      mem [1024];     // 4 KB source window at 28'h2000000
    logic       pending;
    logic [1:0] wait_cnt;
    logic       rnw_q;
    addr_t      adr_q;
    word_t      wdata_q;
    logic       dword_q;

    initial begin
        mem_done = 1'b0;
        wr_seen  = 1'b0;
        pending  = 1'b0;
        wait_cnt = 2'd0;
    end

    // one access at a time answered 1 to 4 cycles after the strobe
    always @(posedge clk100) begin
        mem_done <= 1'b0;
        wr_seen  <= 1'b0;
        if (reset) begin
            pending <= 1'b0;
        end else if (mem_ena) begin
            pending  <= 1'b1;
            wait_cnt <= next_lat;
            rnw_q    <= mem_rnw;
            adr_q    <= mem_adr;
            wdata_q  <= mem_wdata;
            dword_q  <= mem_dword;
        end else if (pending) begin
            if (wait_cnt == 2'd0) begin
                pending  <= 1'b0;
                mem_done <= 1'b1;
                if (rnw_q) begin
                    mem_rdata <= mem[adr_q[11:2]];
                end else begin
                    wr_seen  <= 1'b1;     // writes are only logged
                    wr_adr   <= adr_q;
                    wr_data  <= wdata_q;
                    wr_dword <= dword_q;
                end
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

/* testbench/tb_dma.sv */
module tb_dma;
    import dma_pkg::*;

    localparam logic [27:0] SRC_BASE = 28'h2000000;
    localparam logic [27:0] DST_BASE = 28'h3000000;
    localparam logic [1:0]  T_NOW = 2'd0;
    localparam logic [1:0]  T_VBLANK = 2'd1;
    localparam logic [1:0]  T_HBLANK = 2'd2;
    localparam logic [1:0]  A_INC = 2'd0;
    localparam logic [1:0]  A_DEC = 2'd1;
    localparam logic [1:0]  A_FIXED = 2'd2;
    localparam logic [1:0]  A_RELOAD = 2'd3;
    localparam int WAIT_LIMIT = 2000;
    localparam int MAX_UNITS = 16 + 16 + 3 * 8 + 8 + 8;
    localparam int UNIT_CYCLES = 16;    // worst read plus write plus overhead
    localparam int WATCHDOG_CYCLES = MAX_UNITS * UNIT_CYCLES + 4000;

    logic        clk100;
    logic        reset;
    logic        reg_ena;
    logic        reg_rnw;
    reg_adr_t    reg_adr;
    word_t       reg_wdata;
    logic        vblank;
    logic        hblank;
    logic        mem_done;
    word_t       mem_rdata;
    word_t       reg_rdata;
    logic        reg_rvalid;
    chan_vec_t   irq;
    logic        dma_on;
    logic        mem_ena;
    logic        mem_rnw;
    addr_t       mem_adr;
    logic        mem_dword;
    word_t       mem_wdata;
    logic        wr_seen;
    addr_t       wr_adr;
    word_t       wr_data;
    logic        wr_dword;
    logic [1:0]  next_lat = 2'd0;
    logic [15:0] lfsr = 16'd36461;
    logic [15:0] lat_lfsr = 16'd36461;
    logic [31:0] lat_val;
    word_t       src_copy [1024];
    int          irq_cnt [4] = '{default: 0};
    int          errors = 0;
    int          checks = 0;
    logic [27:0] got_adr [$];
    logic [31:0] got_data [$];
    logic        got_dw [$];
    logic [27:0] exp_adr [$];
    logic [31:0] exp_data [$];
    logic        exp_dw [$];

    tb_clock u_clock (.clk100(clk100), .reset(reset));

    dma_top u_dma_top (
        .clk100     (clk100),
        .reset      (reset),
        .reg_ena    (reg_ena),
        .reg_rnw    (reg_rnw),
        .reg_adr    (reg_adr),
        .reg_wdata  (reg_wdata),
        .vblank     (vblank),
        .hblank     (hblank),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .irq        (irq),
        .dma_on     (dma_on),
        .mem_ena    (mem_ena),
        .mem_rnw    (mem_rnw),
        .mem_adr    (mem_adr),
        .mem_dword  (mem_dword),
        .mem_wdata  (mem_wdata)
    );

    tb_memory u_mem (
        .clk100    (clk100),
        .reset     (reset),
        .mem_ena   (mem_ena),
        .mem_rnw   (mem_rnw),
        .mem_adr   (mem_adr),
        .mem_dword (mem_dword),
        .mem_wdata (mem_wdata),
        .next_lat  (next_lat),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .wr_seen   (wr_seen),
        .wr_adr    (wr_adr),
        .wr_data   (wr_data),
        .wr_dword  (wr_dword)
    );

    // 16-bit Galois LFSR with taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v  = {v[30:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    task automatic rand_val(input int n, output logic [31:0] v);
        take_bits(lfsr, n, v);
    endtask

    function automatic logic [31:0] cnt_word(input logic en, input logic irq_on,
                                             input logic [1:0] tmg, input logic dw,
                                             input logic rep, input logic [1:0] srcc,
                                             input logic [1:0] dstc, input logic [15:0] n);
        return {en, irq_on, tmg, 1'b0, dw, rep, srcc, dstc, 5'b0, n};
    endfunction

    // what the engine should write for one unit read from a
    function automatic logic [31:0] model_data(input logic [27:0] a, input logic dw);
        logic [31:0] w;
        w = src_copy[a[11:2]];
        if (dw)
            return w;
        return a[1] ? {w[31:16], w[31:16]} : {w[15:0], w[15:0]};
    endfunction

    function automatic logic [27:0] step_adr(input logic [27:0] a, input logic [1:0] mode,
                                             input logic dw);
        logic [27:0] s;
        s = dw ? 28'd4 : 28'd2;
        case (mode)
            A_DEC:   return a - s;
            A_FIXED: return a;
            default: return a + s;
        endcase
    endfunction

    task automatic expect_write(input logic [27:0] a, input logic [31:0] d, input logic dw);
        exp_adr.push_back(dw ? {a[27:2], 2'b00} : {a[27:1], 1'b0});
        exp_data.push_back(d);
        exp_dw.push_back(dw);
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_writes();
        int n;
        check("write count", 32'(got_adr.size()), 32'(exp_adr.size()));
        n = (got_adr.size() < exp_adr.size()) ? got_adr.size() : exp_adr.size();
        for (int k = 0; k < n; k++) begin
            check("write address", 32'(got_adr[k]), 32'(exp_adr[k]));
            check("write data", got_data[k], exp_data[k]);
            check("write size", 32'(got_dw[k]), 32'(exp_dw[k]));
        end
        got_adr.delete();
        got_data.delete();
        got_dw.delete();
        exp_adr.delete();
        exp_data.delete();
        exp_dw.delete();
    endtask

    task automatic tick(input int n = 1);
        repeat (n) begin
            @(posedge clk100);
            #2;
        end
    endtask

    task automatic reg_write(input logic [7:0] adr, input logic [31:0] data);
        reg_ena   = 1'b1;
        reg_rnw   = 1'b0;
        reg_adr   = adr;
        reg_wdata = data;
        tick();
        reg_ena = 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] adr, output logic [31:0] data);
        int n;
        reg_ena = 1'b1;
        reg_rnw = 1'b1;
        reg_adr = adr;
        tick();
        reg_ena = 1'b0;
        reg_rnw = 1'b0;
        n = 0;
        while (!reg_rvalid && n < 8) begin
            tick();
            n++;
        end
        data = reg_rdata;
        if (!reg_rvalid) begin
            errors++;
            $display("register read at %h got no response", adr);
        end
    endtask

    task automatic setup_channel(input int ch, input logic [27:0] s, input logic [27:0] d,
                                 input logic [31:0] cnt);
        logic [7:0] base;
        base = 8'hB0 + 8'(ch * 12);
        reg_write(base, {4'h0, s});
        reg_write(base + 8'd4, {4'h0, d});
        reg_write(base + 8'd8, cnt);
    endtask

    task automatic blank_pulse(input logic vert);
        if (vert)
            vblank = 1'b1;
        else
            hblank = 1'b1;
        tick();
        vblank = 1'b0;
        hblank = 1'b0;
    endtask

    task automatic wait_irq(input int ch, input int target);
        int n;
        n = 0;
        while (irq_cnt[ch] < target && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (irq_cnt[ch] < target) begin
            errors++;
            $display("channel %0d never raised its interrupt", ch);
        end
        tick(4);
    endtask

    always @(posedge clk100) begin
        #2;
        take_bits(lat_lfsr, 2, lat_val);
        next_lat = lat_val[1:0];
    end

    always @(posedge clk100) begin
        if (wr_seen) begin
            got_adr.push_back(wr_adr);
            got_data.push_back(wr_data);
            got_dw.push_back(wr_dword);
        end
        if (mem_ena)
            check("dma_on", 32'(dma_on), 32'd1);    // CPU held during every access
        for (int i = 0; i < 4; i++)
            if (irq[i])
                irq_cnt[i] <= irq_cnt[i] + 1;
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] v;
        logic [31:0] cw;
        logic [27:0] s;
        logic [27:0] d;
        int          n;
        int          n2;
        int          base;
        int          base2;
        reg_ena   = 1'b0;
        reg_rnw   = 1'b0;
        reg_adr   = '0;
        reg_wdata = '0;
        vblank    = 1'b0;
        hblank    = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            rand_val(32, v);
            src_copy[i]  = v;
            u_mem.mem[i] = v;
        end
        @(negedge reset);
        tick(3);

        // immediate word copy on channel 0 then irq and CNT readback
        rand_val(4, v);
        n = int'(v[3:0]) + 1;
        rand_val(8, v);
        s = SRC_BASE + {18'd0, v[7:0], 2'b00};
        rand_val(8, v);
        d = DST_BASE + {18'd0, v[7:0], 2'b00};
        cw = cnt_word(1'b1, 1'b1, T_NOW, 1'b1, 1'b0, A_INC, A_INC, 16'(n));
        base = irq_cnt[0];
        setup_channel(0, s, d, cw);
        for (int k = 0; k < n; k++) begin
            expect_write(d, model_data(s, 1'b1), 1'b1);
            s = step_adr(s, A_INC, 1'b1);
            d = step_adr(d, A_INC, 1'b1);
        end
        wait_irq(0, base + 1);
        compare_writes();
        tick(10);
        check("irq pulses on channel 0", 32'(irq_cnt[0] - base), 32'd1);
        reg_read(8'hB8, v);
        check("CNT readback of channel 0", v, cw & 32'h77E0_0000);

        // halfword copy with source down and destination fixed
        rand_val(4, v);
        n = int'(v[3:0]) + 1;
        rand_val(8, v);
        s = SRC_BASE + 28'h800 + {19'd0, v[7:0], 1'b0};
        rand_val(4, v);
        d = DST_BASE + 28'h101 + {23'd0, v[3:0], 1'b0};   // odd so the engine aligns it
        base = irq_cnt[1];
        setup_channel(1, s, d,
                      cnt_word(1'b1, 1'b1, T_NOW, 1'b0, 1'b0, A_DEC, A_FIXED, 16'(n)));
        for (int k = 0; k < n; k++) begin
            expect_write(d, model_data(s, 1'b0), 1'b0);
            s = step_adr(s, A_DEC, 1'b0);
        end
        wait_irq(1, base + 1);
        compare_writes();

        // three vblank repeat blocks with destination reload
        rand_val(3, v);
        n = int'(v[2:0]) + 1;
        rand_val(6, v);
        s = SRC_BASE + 28'h400 + {20'd0, v[5:0], 2'b00};
        d = DST_BASE + 28'h200;
        cw = cnt_word(1'b1, 1'b1, T_VBLANK, 1'b1, 1'b1, A_INC, A_RELOAD, 16'(n));
        setup_channel(2, s, d, cw);
        tick(10);
        compare_writes();               // nothing before the first pulse
        for (int b = 0; b < 3; b++) begin
            base = irq_cnt[2];
            blank_pulse(1'b1);
            d = DST_BASE + 28'h200;
            for (int k = 0; k < n; k++) begin
                expect_write(d, model_data(s, 1'b1), 1'b1);
                s = step_adr(s, A_INC, 1'b1);
                d = step_adr(d, A_INC, 1'b1);
            end
            wait_irq(2, base + 1);
            compare_writes();
            tick(20);
            compare_writes();           // idle between pulses
        end
        reg_write(8'hB0 + 8'd32, cw & 32'h7FFF_FFFF);

        // channel 1 before channel 2 on one hblank
        rand_val(3, v);
        n = int'(v[2:0]) + 1;
        rand_val(3, v);
        n2 = int'(v[2:0]) + 1;
        base2 = irq_cnt[2];
        setup_channel(1, SRC_BASE + 28'h600, DST_BASE + 28'h300,
                      cnt_word(1'b1, 1'b1, T_HBLANK, 1'b1, 1'b0, A_INC, A_INC, 16'(n)));
        setup_channel(2, SRC_BASE + 28'hA00, DST_BASE + 28'h380,
                      cnt_word(1'b1, 1'b1, T_HBLANK, 1'b1, 1'b0, A_INC, A_INC, 16'(n2)));
        tick(5);
        compare_writes();
        blank_pulse(1'b0);
        for (int k = 0; k < n; k++)
            expect_write(DST_BASE + 28'h300 + 28'(k * 4),
                         model_data(SRC_BASE + 28'h600 + 28'(k * 4), 1'b1), 1'b1);
        for (int k = 0; k < n2; k++)
            expect_write(DST_BASE + 28'h380 + 28'(k * 4),
                         model_data(SRC_BASE + 28'hA00 + 28'(k * 4), 1'b1), 1'b1);
        wait_irq(2, base2 + 1);
        compare_writes();

        // channel 3 armed on vblank then cancelled
        cw = cnt_word(1'b1, 1'b0, T_VBLANK, 1'b1, 1'b0, A_INC, A_INC, 16'd2);
        setup_channel(3, SRC_BASE, DST_BASE + 28'h400, cw);
        tick(3);
        reg_write(8'hB0 + 8'd44, cw & 32'h7FFF_FFFF);
        tick(3);
        blank_pulse(1'b1);
        tick(80);
        compare_writes();
        check("dma_on after cancel", 32'(dma_on), 32'd0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* tb.f */
verilog/dma_pkg.sv
verilog/dma_regs.sv
verilog/dma_channel.sv
verilog/dma_bus_engine.sv
verilog/dma_top.sv
testbench/tb_clock.sv
testbench/tb_memory.sv
testbench/tb_dma.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_dma
FILELIST = tb.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
